//--- common/positPkg.sv
/*
  posit field unit package
  shared sizes, AXI register offsets, result buffer slot indices
  and the 32-bit result word that carries either a raw posit or
  its decoded fields
*/
`default_nettype none

package positPkg;

  // ====================================================================
  // posit sizes
  // ====================================================================
  // default posit width and exponent size
  localparam int PSTWID_DEF = 16;
  localparam int ES_DEF = 1;
  // regime count width, enough for widths up to 16
  localparam int RS_W = 5;

  // ====================================================================
  // register map, byte offsets on a 5-bit address
  // ====================================================================
  localparam logic [4:0] ADDR_OPERAND = 5'h00;
  localparam logic [4:0] ADDR_FIELDS = 5'h04;
  localparam logic [4:0] ADDR_RESULT0 = 5'h08;
  localparam logic [4:0] ADDR_RESULT1 = 5'h0C;
  localparam logic [4:0] ADDR_STATUS = 5'h10;

  // result buffer slots
  localparam logic SLOT_DECOMP = 1'b0;
  localparam logic SLOT_COMP = 1'b1;

  // result word, raw posit view or field view
  typedef union packed {
    struct packed {
      logic [15:0] pad;
      // posit sits in the low half
      logic [15:0] posit;
    } raw;
    struct packed {
      logic sgn;
      logic zer;
      logic inf;
      logic rgs;
      logic [RS_W-1:0] rgm;
      // unused high exponent bits stay zero
      logic [1:0] exp;
      logic [4:0] pad;
      // left aligned, hidden bit on top
      logic [15:0] sig;
    } fields;
  } resultWordT;

endpackage

`default_nettype wire

//--- common/resultBusIf.sv
/*
  result write bus
  one requester per unit, the arbiter answers with a grant
  and writes the data into the requested buffer slot
*/
`timescale 1ns/1ps
`default_nettype none

interface resultBusIf;
  import positPkg::*;

  // request held until grant
  logic req;
  logic gnt;
  // target buffer slot
  logic slot;
  resultWordT data;

  // unit side
  modport requester (
    output req,
    output slot,
    output data,
    input gnt
  );

  // arbiter side
  modport arbiter (
    input req,
    input slot,
    input data,
    output gnt
  );

endinterface

`default_nettype wire

//--- verilog/axiLiteRegs.sv
/*
  AXI4-Lite register slave
  one transaction at a time, decodes the register map,
  pulses the unit starts and clears the matching done flags,
  returns buffer slots and the status word on reads
*/
`timescale 1ns/1ps
`default_nettype none

module axiLiteRegs #(
  parameter int PSTWID = positPkg::PSTWID_DEF
) (
  input logic clk,
  input logic reset,
  // write address and data
  input logic [4:0] awaddr,
  input logic awvalid,
  output logic awready,
  input logic [31:0] wdata,
  input logic wvalid,
  output logic wready,
  // write response
  output logic bvalid,
  output logic [1:0] bresp,
  input logic bready,
  // read address and data
  input logic [4:0] araddr,
  input logic arvalid,
  output logic arready,
  output logic rvalid,
  output logic [31:0] rdata,
  output logic [1:0] rresp,
  input logic rready,
  // unit controls
  output logic decStart,
  output logic [PSTWID-1:0] decOperand,
  output logic encStart,
  output positPkg::resultWordT encFields,
  output logic [1:0] clearDone,
  // buffer and status
  input positPkg::resultWordT slot0,
  input positPkg::resultWordT slot1,
  input logic [1:0] done
);
  import positPkg::*;

  logic wrFire;
  logic rdFire;
  logic [31:0] readMux;

  // always OKAY
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // ====================================================================
  // write channel
  // ====================================================================
  // awready and wready move together
  assign wrFire = awready & awvalid & wready & wvalid;

  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
      decStart <= 1'b0;
      encStart <= 1'b0;
      clearDone <= 2'b00;
    end else begin
      // pulses last one cycle
      decStart <= 1'b0;
      encStart <= 1'b0;
      clearDone <= 2'b00;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wrFire) begin
        awready <= 1'b0;
        wready <= 1'b0;
        bvalid <= 1'b1;
        case (awaddr)
          ADDR_OPERAND: begin
            decStart <= 1'b1;
            clearDone <= 2'b01;
          end
          ADDR_FIELDS: begin
            encStart <= 1'b1;
            clearDone <= 2'b10;
          end
          default: ;
        endcase
      end else if (!awready && !bvalid && awvalid && wvalid) begin
        // both channels present, no response pending
        awready <= 1'b1;
        wready <= 1'b1;
      end
    end
  end

  // operand registers follow the start pulses
  always_ff @(posedge clk) begin
    if (wrFire) begin
      case (awaddr)
        ADDR_OPERAND: decOperand <= wdata[PSTWID-1:0];
        ADDR_FIELDS: encFields <= wdata;
        default: ;
      endcase
    end
  end

  // ====================================================================
  // read channel
  // ====================================================================
  assign rdFire = arready & arvalid;

  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (rdFire) begin
        arready <= 1'b0;
        rvalid <= 1'b1;
      end else if (!arready && !rvalid && arvalid) begin
        arready <= 1'b1;
      end
    end
  end

  // unknown offsets read as zero
  always_comb begin
    case (araddr)
      ADDR_OPERAND: readMux = 32'(decOperand);
      ADDR_FIELDS: readMux = encFields;
      ADDR_RESULT0: readMux = slot0;
      ADDR_RESULT1: readMux = slot1;
      ADDR_STATUS: readMux = {30'd0, done};
      default: readMux = 32'd0;
    endcase
  end

  // data captured on the address handshake
  always_ff @(posedge clk) begin
    if (rdFire) begin
      rdata <= readMux;
    end
  end

endmodule

`default_nettype wire

//--- positDecode/positDecompose.sv
/*
  posit decomposer
  two-stage pipeline splitting a raw posit into sign, zero and
  infinity flags, regime sign and magnitude, exponent and a
  left-aligned significand, written to the result bus
*/
`timescale 1ns/1ps
`default_nettype none

module positDecompose #(
  parameter int PSTWID = positPkg::PSTWID_DEF,
  parameter int ES = positPkg::ES_DEF
) (
  input logic clk,
  input logic reset,
  input logic start,
  input logic [PSTWID-1:0] operand,
  resultBusIf.requester bus
);
  import positPkg::*;

  // alignment width for exponent and fraction extraction
  localparam int AL_W = 18;

  // length of the leading run of bitVal from the top
  function automatic logic [RS_W-1:0] runLength(
    input logic [PSTWID-2:0] x,
    input logic bitVal
  );
    logic [RS_W-1:0] n;
    logic stop;
    n = '0;
    stop = 1'b0;
    for (int i = PSTWID - 2; i >= 0; i--) begin
      if (!stop && x[i] == bitVal) begin
        n = n + 1'b1;
      end else begin
        stop = 1'b1;
      end
    end
    return n;
  endfunction

  logic advance;
  logic s1Valid;
  logic s1Sgn;
  logic s1Zer;
  logic s1Inf;
  logic [PSTWID-1:0] s1Abs;
  logic [RS_W-1:0] s1Zeros;
  logic [RS_W-1:0] s1Ones;
  logic [PSTWID-1:0] absC;
  logic rgsC;
  logic [RS_W-1:0] runC;
  logic [PSTWID-1:0] shiftedC;
  logic [AL_W-1:0] wideC;
  logic [AL_W-1:0] fracC;
  resultWordT fieldsC;
  logic reqQ;
  resultWordT outWord;

  // ====================================================================
  // stage 1: flags, magnitude, run counts
  // ====================================================================
  // two's complement of negative posits
  assign absC = operand[PSTWID-1] ? -operand : operand;

  // output stage waiting on a grant holds everything
  assign advance = ~reqQ | bus.gnt;

  always_ff @(posedge clk) begin
    if (advance && start) begin
      s1Sgn <= operand[PSTWID-1];
      s1Zer <= ~|operand;
      s1Inf <= operand[PSTWID-1] & ~|operand[PSTWID-2:0];
      s1Abs <= absC;
      s1Zeros <= runLength(absC[PSTWID-2:0], 1'b0);
      s1Ones <= runLength(absC[PSTWID-2:0], 1'b1);
    end
  end

  // ====================================================================
  // stage 2: regime, exponent, significand
  // ====================================================================
  always_comb begin
    rgsC = s1Abs[PSTWID-2];
    runC = rgsC ? s1Ones : s1Zeros;
    // drop the run and its terminator
    shiftedC = s1Abs << (runC + 1'b1);
    wideC = {shiftedC[PSTWID-2:0], {(AL_W - PSTWID + 1){1'b0}}};
    // exponent bits sit below the terminator
    fracC = wideC << ES;
    fieldsC = '0;
    fieldsC.fields.sgn = s1Sgn;
    fieldsC.fields.zer = s1Zer;
    fieldsC.fields.inf = s1Inf;
    fieldsC.fields.rgs = rgsC;
    // run of ones counts from zero
    fieldsC.fields.rgm = rgsC ? s1Ones - 1'b1 : s1Zeros;
    fieldsC.fields.exp = wideC[AL_W-1 -: 2] >> (2 - ES);
    // hidden bit set unless zero
    fieldsC.fields.sig = {~s1Zer, fracC[AL_W-1 -: 15]};
  end

  always_ff @(posedge clk) begin
    if (advance && s1Valid) begin
      outWord <= fieldsC;
    end
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      s1Valid <= 1'b0;
      reqQ <= 1'b0;
    end else if (advance) begin
      s1Valid <= start;
      reqQ <= s1Valid;
    end
  end

  assign bus.req = reqQ;
  assign bus.slot = SLOT_DECOMP;
  assign bus.data = outWord;

endmodule

`default_nettype wire

//--- positEncode/positCompose.sv
/*
  posit composer
  two-stage pipeline building a raw posit from a field word,
  regime run and terminator, exponent and fraction, then
  truncation, sign and special values, written to the result bus
*/
`timescale 1ns/1ps
`default_nettype none

module positCompose #(
  parameter int PSTWID = positPkg::PSTWID_DEF,
  parameter int ES = positPkg::ES_DEF
) (
  input logic clk,
  input logic reset,
  input logic start,
  input positPkg::resultWordT fields,
  resultBusIf.requester bus
);
  import positPkg::*;

  logic advance;
  logic [RS_W-1:0] runC;
  logic [16:0] expFracC;
  logic signed [34:0] seedC;
  logic signed [34:0] runWordC;
  logic s1Valid;
  logic s1Sgn;
  logic s1Zer;
  logic s1Inf;
  logic [33:0] s1Body;
  logic [PSTWID-2:0] magC;
  logic [PSTWID-1:0] pstC;
  resultWordT wordC;
  logic reqQ;
  resultWordT outWord;

  // stall while the result waits for a grant
  assign advance = ~reqQ | bus.gnt;

  // ====================================================================
  // stage 1: regime run, exponent, fraction
  // ====================================================================
  always_comb begin
    // run of ones is one longer than rgm
    runC = fields.fields.rgs ? fields.fields.rgm + 1'b1 : fields.fields.rgm;
    // exponent low ES bits on top, fraction below the hidden bit
    expFracC = {fields.fields.exp, fields.fields.sig[14:0]} << (2 - ES);
    // extra leading copy of rgs feeds the arithmetic shift
    seedC = {fields.fields.rgs, ~fields.fields.rgs, expFracC, 16'h0000};
    runWordC = seedC >>> runC;
  end

  always_ff @(posedge clk) begin
    if (advance && start) begin
      s1Sgn <= fields.fields.sgn;
      s1Zer <= fields.fields.zer;
      s1Inf <= fields.fields.inf;
      s1Body <= runWordC[33:0];
    end
  end

  // ====================================================================
  // stage 2: truncate, sign, special values
  // ====================================================================
  always_comb begin
    magC = s1Body[33 -: PSTWID-1];
    pstC = {1'b0, magC};
    if (s1Sgn) begin
      pstC = -pstC;
    end
    if (s1Zer) begin
      pstC = '0;
    end else if (s1Inf) begin
      // NaR pattern
      pstC = {1'b1, {(PSTWID - 1){1'b0}}};
    end
    wordC = '0;
    wordC.raw.posit[PSTWID-1:0] = pstC;
  end

  always_ff @(posedge clk) begin
    if (advance && s1Valid) begin
      outWord <= wordC;
    end
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      s1Valid <= 1'b0;
      reqQ <= 1'b0;
    end else if (advance) begin
      s1Valid <= start;
      reqQ <= s1Valid;
    end
  end

  assign bus.req = reqQ;
  assign bus.slot = SLOT_COMP;
  assign bus.data = outWord;

endmodule

`default_nettype wire

//--- verilog/resultArbiter.sv
/*
  result bus arbiter
  fixed priority, decomposer first, owns the two-slot result
  buffer and the per-slot done flags
*/
`timescale 1ns/1ps
`default_nettype none

module resultArbiter (
  input logic clk,
  input logic reset,
  resultBusIf.arbiter decBus,
  resultBusIf.arbiter encBus,
  input logic [1:0] clearDone,
  output positPkg::resultWordT slot0,
  output positPkg::resultWordT slot1,
  output logic [1:0] done
);
  import positPkg::*;

  logic wrEn;
  logic wrSlot;
  resultWordT wrData;
  resultWordT buffer [2];

  // grant in the same cycle as the request
  assign decBus.gnt = decBus.req;
  // composer waits while the decomposer requests
  assign encBus.gnt = encBus.req & ~decBus.req;

  // winner's write
  always_comb begin
    wrEn = 1'b0;
    wrSlot = decBus.slot;
    wrData = decBus.data;
    if (decBus.req) begin
      wrEn = 1'b1;
    end else if (encBus.req) begin
      wrEn = 1'b1;
      wrSlot = encBus.slot;
      wrData = encBus.data;
    end
  end

  // ====================================================================
  // buffer and done flags
  // ====================================================================
  always_ff @(posedge clk) begin
    if (wrEn) begin
      buffer[wrSlot] <= wrData;
    end
  end

  // landing result wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 2'b00;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (wrEn && wrSlot == 1'(i)) begin
          done[i] <= 1'b1;
        end else if (clearDone[i]) begin
          done[i] <= 1'b0;
        end
      end
    end
  end

  assign slot0 = buffer[SLOT_DECOMP];
  assign slot1 = buffer[SLOT_COMP];

endmodule

`default_nettype wire

//--- verilog/positUnitTop.sv
/*
  posit field unit top
  AXI4-Lite slave, decomposer, composer and the result bus
  arbiter with its buffer
*/
`timescale 1ns/1ps
`default_nettype none

module positUnitTop #(
  parameter int PSTWID = positPkg::PSTWID_DEF,
  parameter int ES = positPkg::ES_DEF
) (
  input logic clk,
  input logic reset,
  input logic [4:0] awaddr,
  input logic awvalid,
  output logic awready,
  input logic [31:0] wdata,
  input logic wvalid,
  output logic wready,
  output logic bvalid,
  output logic [1:0] bresp,
  input logic bready,
  input logic [4:0] araddr,
  input logic arvalid,
  output logic arready,
  output logic rvalid,
  output logic [31:0] rdata,
  output logic [1:0] rresp,
  input logic rready
);
  import positPkg::*;

  logic decStart;
  logic [PSTWID-1:0] decOperand;
  logic encStart;
  resultWordT encFields;
  logic [1:0] clearDone;
  resultWordT slot0;
  resultWordT slot1;
  logic [1:0] done;

  // one bus per unit
  resultBusIf decBus ();
  resultBusIf encBus ();

  axiLiteRegs #(
    .PSTWID(PSTWID)
  ) regs (
    .clk(clk),
    .reset(reset),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wvalid(wvalid),
    .wready(wready),
    .bvalid(bvalid),
    .bresp(bresp),
    .bready(bready),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rvalid(rvalid),
    .rdata(rdata),
    .rresp(rresp),
    .rready(rready),
    .decStart(decStart),
    .decOperand(decOperand),
    .encStart(encStart),
    .encFields(encFields),
    .clearDone(clearDone),
    .slot0(slot0),
    .slot1(slot1),
    .done(done)
  );

  positDecompose #(
    .PSTWID(PSTWID),
    .ES(ES)
  ) decomp (
    .clk(clk),
    .reset(reset),
    .start(decStart),
    .operand(decOperand),
    .bus(decBus.requester)
  );

  positCompose #(
    .PSTWID(PSTWID),
    .ES(ES)
  ) comp (
    .clk(clk),
    .reset(reset),
    .start(encStart),
    .fields(encFields),
    .bus(encBus.requester)
  );

  resultArbiter arb (
    .clk(clk),
    .reset(reset),
    .decBus(decBus.arbiter),
    .encBus(encBus.arbiter),
    .clearDone(clearDone),
    .slot0(slot0),
    .slot1(slot1),
    .done(done)
  );

endmodule

`default_nettype wire

//--- tb/positUnit_props.sv
/*
  posit field unit properties
  AXI response hold, single grant, results landing on the
  edge after a grant and request hold on the composer bus
*/
`timescale 1ns/1ps
`default_nettype none

module positUnit_props (
  input logic clk,
  input logic reset,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic [31:0] rdata,
  input logic decReq,
  input logic decGnt,
  input logic encReq,
  input logic encGnt,
  input logic [31:0] encData,
  input logic [1:0] done
);

  // ====================================================================
  // AXI responses
  // ====================================================================
  bvalidHold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // read data must not move while waiting
  rvalidHold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  // ====================================================================
  // result bus
  // ====================================================================
  singleGrant: assert property (@(posedge clk) disable iff (reset)
    !(decGnt && encGnt))
    else $error("both requesters granted");

  // decomposer never waits, its slot is done one edge later
  decomposeNoWait: assert property (@(posedge clk) disable iff (reset)
    decReq |=> done[0])
    else $error("decomposer result did not land after its request");

  composeLands: assert property (@(posedge clk) disable iff (reset)
    encGnt |=> done[1])
    else $error("composer result did not land after its grant");

  encHold: assert property (@(posedge clk) disable iff (reset)
    encReq && !encGnt |=> encReq && $stable(encData))
    else $error("composer request dropped before grant");

endmodule

bind positUnitTop positUnit_props props (
  .clk(clk),
  .reset(reset),
  .bvalid(bvalid),
  .bready(bready),
  .rvalid(rvalid),
  .rready(rready),
  .rdata(rdata),
  .decReq(decBus.req),
  .decGnt(decBus.gnt),
  .encReq(encBus.req),
  .encGnt(encBus.gnt),
  .encData(encBus.data),
  .done(done)
);

`default_nettype wire

//--- tb/positUnitTb.sv
/*
  posit field unit testbench
  drives the AXI4-Lite ports, decomposes fixed and random posits,
  composes them back, checks arbitration results, done clearing
  and unused offsets against a reference model
*/
`timescale 1ns/1ps
`default_nettype none

module positUnitTb;
  import positPkg::*;

  localparam int PSTWID = PSTWID_DEF;
  localparam int ES = ES_DEF;
  // handshake and polling bounds
  localparam int WAIT_LIMIT = 40;
  localparam int POLL_LIMIT = 40;
  localparam int RANDOM_COUNT = 200;
  localparam logic [15:0] FIXED_OPS [5] = '{16'h0000, 16'h8000, 16'h4000, 16'hC000, 16'h7FFF};

  logic clk;
  logic reset;
  logic [4:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic [1:0] bresp;
  logic bready;
  logic [4:0] araddr;
  logic arvalid;
  logic arready;
  logic rvalid;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rready;

  int errorCount;
  int testMark;
  int testsPassed;
  int testsFailed;
  // cycles that bready and rready stay low once a response is up
  int respStall;
  logic [PSTWID-1:0] randOps [RANDOM_COUNT];
  resultWordT randFields [RANDOM_COUNT];

  positUnitTop #(
    .PSTWID(PSTWID),
    .ES(ES)
  ) UUT (
    .clk(clk),
    .reset(reset),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wvalid(wvalid),
    .wready(wready),
    .bvalid(bvalid),
    .bresp(bresp),
    .bready(bready),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rvalid(rvalid),
    .rdata(rdata),
    .rresp(rresp),
    .rready(rready)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ====================================================================
  // reference model
  // ====================================================================
  // split a raw posit into its fields
  function automatic resultWordT decomposeModel(input logic [PSTWID-1:0] p);
    resultWordT w;
    logic [PSTWID-1:0] absV;
    logic [31:0] rest;
    logic stop;
    int run;
    w = '0;
    absV = p[PSTWID-1] ? -p : p;
    w.fields.sgn = p[PSTWID-1];
    w.fields.zer = (p == '0);
    w.fields.inf = (p == {1'b1, {(PSTWID - 1){1'b0}}});
    w.fields.rgs = absV[PSTWID-2];
    run = 0;
    stop = 1'b0;
    for (int k = PSTWID - 2; k >= 0; k--) begin
      if (!stop && absV[k] == w.fields.rgs) begin
        run++;
      end else begin
        stop = 1'b1;
      end
    end
    w.fields.rgm = RS_W'(w.fields.rgs ? run - 1 : run);
    // bits below the sign, left aligned, then past run and terminator
    rest = 32'(absV[PSTWID-2:0]) << (33 - PSTWID);
    rest = rest << (run + 1);
    w.fields.exp = 2'(rest >> (32 - ES));
    rest = rest << ES;
    w.fields.sig = {~w.fields.zer, rest[31:17]};
    return w;
  endfunction

  // build a raw posit from fields, truncating the fraction
  function automatic resultWordT composeModel(input resultWordT f);
    resultWordT w;
    logic [63:0] body;
    logic [PSTWID-1:0] p;
    int run;
    int pos;
    body = '0;
    pos = 63;
    run = f.fields.rgs ? int'(f.fields.rgm) + 1 : int'(f.fields.rgm);
    for (int k = 0; k < run; k++) begin
      body[pos] = f.fields.rgs;
      pos--;
    end
    // terminator
    body[pos] = ~f.fields.rgs;
    pos--;
    for (int e = ES - 1; e >= 0; e--) begin
      body[pos] = f.fields.exp[e];
      pos--;
    end
    for (int b = 14; b >= 0; b--) begin
      body[pos] = f.fields.sig[b];
      pos--;
    end
    p = {1'b0, body[63 -: PSTWID-1]};
    if (f.fields.sgn) begin
      p = -p;
    end
    if (f.fields.zer) begin
      p = '0;
    end else if (f.fields.inf) begin
      p = {1'b1, {(PSTWID - 1){1'b0}}};
    end
    w = '0;
    w.raw.posit[PSTWID-1:0] = p;
    return w;
  endfunction

  // ====================================================================
  // checks and bookkeeping
  // ====================================================================
  task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
    assert (got === expected) else begin
      errorCount++;
      $display("error at %0t ns: %s, got %h expected %h", $time, what, got, expected);
    end
  endtask

  task automatic stopOnTimeout(input string why);
    $display("timeout: %s", why);
    $display("TB FAILED");
    $finish;
  endtask

  task automatic openTest();
    testMark = errorCount;
  endtask

  task automatic closeTest(input string name);
    if (errorCount == testMark) begin
      testsPassed++;
      $display("test %s: passed", name);
    end else begin
      testsFailed++;
      $display("test %s: failed with %0d errors", name, errorCount - testMark);
    end
  endtask

  // ====================================================================
  // AXI4-Lite tasks, each entered right after a rising edge
  // ====================================================================
  task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
    int waitCount;
    awaddr <= addr;
    wdata <= data;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    bready <= (respStall == 0);
    @(posedge clk);
    waitCount = 1;
    while (!awready) begin
      if (waitCount >= WAIT_LIMIT) stopOnTimeout("no awready on a register write");
      @(posedge clk);
      waitCount++;
    end
    // address and data ready rise together
    checkValue(32'(wready), 32'd1, "wready together with awready");
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    @(posedge clk);
    waitCount = 1;
    while (!bvalid) begin
      if (waitCount >= WAIT_LIMIT) stopOnTimeout("no bvalid on a register write");
      @(posedge clk);
      waitCount++;
    end
    checkValue(32'(bresp), 32'd0, "write response code");
    // response waits for a late bready
    if (respStall > 0) begin
      repeat (respStall - 1) @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
    end
    bready <= 1'b0;
  endtask

  task automatic readReg(input logic [4:0] addr, output logic [31:0] data);
    int waitCount;
    araddr <= addr;
    arvalid <= 1'b1;
    rready <= (respStall == 0);
    @(posedge clk);
    waitCount = 1;
    while (!arready) begin
      if (waitCount >= WAIT_LIMIT) stopOnTimeout("no arready on a register read");
      @(posedge clk);
      waitCount++;
    end
    arvalid <= 1'b0;
    @(posedge clk);
    waitCount = 1;
    while (!rvalid) begin
      if (waitCount >= WAIT_LIMIT) stopOnTimeout("no rvalid on a register read");
      @(posedge clk);
      waitCount++;
    end
    checkValue(32'(rresp), 32'd0, "read response code");
    data = rdata;
    // read data waits for a late rready
    if (respStall > 0) begin
      repeat (respStall - 1) @(posedge clk);
      rready <= 1'b1;
      @(posedge clk);
    end
    rready <= 1'b0;
  endtask

  // poll status until every bit of mask is set
  task automatic waitDone(input logic [1:0] mask);
    logic [31:0] status;
    int polls;
    polls = 0;
    readReg(ADDR_STATUS, status);
    while ((status[1:0] & mask) != mask) begin
      polls++;
      if (polls >= POLL_LIMIT) stopOnTimeout("done flag never set in the status register");
      readReg(ADDR_STATUS, status);
    end
  endtask

  task automatic runDecompose(input logic [PSTWID-1:0] op, output logic [31:0] got);
    writeReg(ADDR_OPERAND, 32'(op));
    waitDone(2'b01);
    readReg(ADDR_RESULT0, got);
  endtask

  task automatic runCompose(input resultWordT f, output logic [31:0] got);
    writeReg(ADDR_FIELDS, f);
    waitDone(2'b10);
    readReg(ADDR_RESULT1, got);
  endtask

  // ====================================================================
  // stimulus
  // ====================================================================
  initial begin
    logic [31:0] got;
    logic [PSTWID-1:0] op;
    resultWordT f;
    errorCount = 0;
    testsPassed = 0;
    testsFailed = 0;
    respStall = 0;
    void'($urandom(83));
    reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // fixed values incl. zero and NaR, responses held two cycles
    openTest();
    respStall = 2;
    for (int i = 0; i < 5; i++) begin
      runDecompose(FIXED_OPS[i][PSTWID-1:0], got);
      checkValue(got, decomposeModel(FIXED_OPS[i][PSTWID-1:0]),
                 $sformatf("decompose %h", FIXED_OPS[i]));
    end
    respStall = 0;
    closeTest("1 fixed decompose");

    openTest();
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      randOps[i] = PSTWID'($urandom());
      runDecompose(randOps[i], got);
      checkValue(got, decomposeModel(randOps[i]), $sformatf("decompose %h", randOps[i]));
      randFields[i] = got;
    end
    closeTest("2 random decompose");

    // round trip back to the operands
    openTest();
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      runCompose(randFields[i], got);
      checkValue(got, composeModel(randFields[i]), $sformatf("compose %h", randFields[i]));
      checkValue(got, 32'(randOps[i]), $sformatf("round trip of %h", randOps[i]));
    end
    closeTest("3 compose round trip");

    // both units busy, writes back to back
    openTest();
    op = PSTWID'($urandom());
    f = decomposeModel(PSTWID'($urandom()));
    writeReg(ADDR_OPERAND, 32'(op));
    writeReg(ADDR_FIELDS, f);
    waitDone(2'b11);
    readReg(ADDR_RESULT0, got);
    checkValue(got, decomposeModel(op), "slot 0 after both units ran");
    readReg(ADDR_RESULT1, got);
    checkValue(got, composeModel(f), "slot 1 after both units ran");
    closeTest("4 both units");

    // status read issued straight after the write response
    openTest();
    op = PSTWID'($urandom());
    writeReg(ADDR_OPERAND, 32'(op));
    readReg(ADDR_STATUS, got);
    checkValue(32'(got[0]), 32'd0, "done0 right after the operand write");
    waitDone(2'b01);
    readReg(ADDR_STATUS, got);
    checkValue(32'(got[0]), 32'd1, "done0 after the result landed");
    readReg(ADDR_RESULT0, got);
    checkValue(got, decomposeModel(op), "slot 0 after done0 cleared");
    closeTest("5 done0 clear");

    openTest();
    readReg(5'h14, got);
    checkValue(got, 32'd0, "unused offset 0x14");
    readReg(5'h1C, got);
    checkValue(got, 32'd0, "unused offset 0x1C");
    closeTest("6 unused offset");

    $display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errorCount);
    if (errorCount == 0 && testsFailed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
common/positPkg.sv
common/resultBusIf.sv
verilog/axiLiteRegs.sv
positDecode/positDecompose.sv
positEncode/positCompose.sv
verilog/resultArbiter.sv
verilog/positUnitTop.sv
tb/positUnit_props.sv
tb/positUnitTb.sv

//--- run.sh
#!/bin/sh
# compile and run the posit field unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f src.f \
  --top-module positUnitTb \
  -o positUnitSim

./obj_dir/positUnitSim | tee sim.log

# the run passes only if the testbench reported success
grep -q "TB PASSED" sim.log
